//--- hw/rv_core_pkg.sv
// shared widths, encodings, ALU codes and control structs, imported by every core module
package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] insn_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;
  typedef logic [3:0]  alu_op_t;

  // major opcodes kept by this core
  localparam opcode_t OP_LUI     = 7'b01_101_11;
  localparam opcode_t OP_REG_IMM = 7'b00_100_11;
  localparam opcode_t OP_REG_REG = 7'b01_100_11;
  localparam opcode_t OP_BRANCH  = 7'b11_000_11;
  localparam opcode_t OP_ENVIRON = 7'b11_100_11;

  // alternate funct7 picks sub and sra
  localparam funct7_t FUNCT7_BASE = 7'b000_0000;
  localparam funct7_t FUNCT7_ALT  = 7'b010_0000;

  // funct3 for ALU instructions
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // funct3 for branches, 010 and 011 are unused
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;

  localparam int IMEM_WORDS = 256;
  typedef logic [$clog2(IMEM_WORDS)-1:0] imem_addr_t;

  localparam word_t PC_STEP = 32'd4;

  // decoded control for one instruction
  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    logic      use_imm;
    alu_op_t   alu_op;
    logic      reg_we;
    logic      is_branch;
    funct3_t   branch_funct;
    logic      is_halt;
  } ctrl_t;

  // writeback trace entry
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

endpackage

//--- hw/rv_imem.sv
// instruction memory, loaded through a write port while stopped and read asynchronously by fetch
`timescale 1ns/10ps

module rv_imem (
  input  logic                   clk,
  input  logic                   we,
  input  rv_core_pkg::imem_addr_t waddr,
  input  rv_core_pkg::insn_t     wdata,
  input  rv_core_pkg::imem_addr_t raddr,
  output rv_core_pkg::insn_t     insn
);
  import rv_core_pkg::*;

  // one instruction per word
  insn_t mem [IMEM_WORDS];

  // program load
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // fetch sees the word in the same cycle
  assign insn = mem[raddr];

endmodule

//--- hw/rv_decoder.sv
// instruction decoder, turns a fetched word into the control struct for the single-cycle core
`timescale 1ns/10ps

module rv_decoder (
  input  rv_core_pkg::insn_t  insn,
  output rv_core_pkg::ctrl_t  ctrl
);
  import rv_core_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  word_t   imm_i;
  word_t   imm_b;
  word_t   imm_u;
  logic    f7_base;
  logic    f7_alt;
  logic    has_alt;
  logic    is_shift;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'd0};

  assign f7_base  = (funct7 == FUNCT7_BASE);
  assign f7_alt   = (funct7 == FUNCT7_ALT);
  // only add/sub and the right shifts have an alternate form
  assign has_alt  = (funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA);
  assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);

  function automatic alu_op_t alu_from_funct3(input funct3_t f3, input logic alt);
    alu_op_t op;
    case (f3)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      F3_AND:     op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl     = '0;
    ctrl.rs1 = insn[19:15];
    ctrl.rs2 = insn[24:20];
    ctrl.rd  = insn[11:7];
    case (opcode)
      OP_LUI: begin
        ctrl.imm     = imm_u;
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = ALU_PASS_B;
        ctrl.reg_we  = 1'b1;
      end
      OP_REG_IMM: begin
        ctrl.imm     = imm_i;
        ctrl.use_imm = 1'b1;
        // addi has no sub form, so alt only matters for srai
        ctrl.alu_op  = alu_from_funct3(funct3, f7_alt && funct3 == F3_SRL_SRA);
        // shift immediates carry funct7 in the upper bits
        ctrl.reg_we  = !is_shift || f7_base || (f7_alt && funct3 == F3_SRL_SRA);
      end
      OP_REG_REG: begin
        ctrl.alu_op = alu_from_funct3(funct3, f7_alt);
        ctrl.reg_we = f7_base || (f7_alt && has_alt);
      end
      OP_BRANCH: begin
        ctrl.imm          = imm_b;
        ctrl.branch_funct = funct3;
        // funct3 010 and 011 are not branches
        ctrl.is_branch    = (funct3[2:1] != 2'b01);
      end
      OP_ENVIRON: begin
        ctrl.is_halt = (insn[31:7] == '0);
      end
      default: begin
        // unknown opcode is a no-op
      end
    endcase
  end

endmodule

//--- hw/rv_alu.sv
// ALU for the single-cycle core, produces the writeback value of every arithmetic and LUI op
`timescale 1ns/10ps

module rv_alu (
  input  rv_core_pkg::alu_op_t op,
  input  rv_core_pkg::word_t   a,
  input  rv_core_pkg::word_t   b,
  output rv_core_pkg::word_t   result
);
  import rv_core_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shifts only look at the low five bits
  assign shamt = b[4:0];

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_SLL: begin
        result = a << shamt;
      end
      ALU_SLT: begin
        result = {31'd0, lt_signed};
      end
      ALU_SLTU: begin
        result = {31'd0, lt_unsigned};
      end
      ALU_XOR: begin
        result = a ^ b;
      end
      ALU_SRL: begin
        result = a >> shamt;
      end
      ALU_SRA: begin
        // arithmetic shift keeps the sign bit
        result = word_t'($signed(a) >>> shamt);
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_PASS_B: begin
        // lui immediate is already in place
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- hw/rv_regfile.sv
// integer register file, two combinational reads and one clocked write with x0 fixed at zero
`timescale 1ns/10ps

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  we,
  input  rv_core_pkg::reg_addr_t rd,
  input  rv_core_pkg::word_t    rd_data,
  input  rv_core_pkg::reg_addr_t rs1,
  input  rv_core_pkg::reg_addr_t rs2,
  output rv_core_pkg::word_t    rs1_data,
  output rv_core_pkg::word_t    rs2_data
);
  import rv_core_pkg::*;

  // x1 to x31, x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hw/rv_pc_unit.sv
// pc register with branch resolution, advances one instruction per clock while running
`timescale 1ns/10ps

module rv_pc_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                run,
  input  rv_core_pkg::ctrl_t  ctrl,
  input  rv_core_pkg::word_t  rs1_data,
  input  rv_core_pkg::word_t  rs2_data,
  output rv_core_pkg::word_t  pc,
  output logic                halt
);
  import rv_core_pkg::*;

  logic  taken;
  word_t pc_next;

  // branch condition
  always_comb begin
    case (ctrl.branch_funct)
      F3_BEQ:  taken = (rs1_data == rs2_data);
      F3_BNE:  taken = (rs1_data != rs2_data);
      F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: taken = (rs1_data < rs2_data);
      F3_BGEU: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  // branch offset comes in the B immediate
  assign pc_next = (ctrl.is_branch && taken) ? pc + ctrl.imm : pc + PC_STEP;

  // ecall stops the pc, so halt holds by itself
  assign halt = ctrl.is_halt;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (run && !halt) begin
      pc <= pc_next;
    end
  end

endmodule

//--- hw/rv_core_top.sv
// top of the single-cycle RV32I core, with program load port, run level and writeback trace
`timescale 1ns/10ps

module rv_core_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   run,
  input  logic                   imem_we,
  input  rv_core_pkg::imem_addr_t imem_addr,
  input  rv_core_pkg::insn_t     imem_wdata,
  output rv_core_pkg::word_t     pc,
  output logic                   halt,
  output rv_core_pkg::wb_t       wb
);
  import rv_core_pkg::*;

  insn_t      insn;
  ctrl_t      ctrl;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_b;
  word_t      alu_result;
  imem_addr_t fetch_addr;
  logic       exec;
  logic       rf_we;

  // word index, upper pc bits wrap around the memory
  assign fetch_addr = pc[$bits(imem_addr_t)+1:2];

  rv_imem rv_imem_inst (
    .clk   (clk),
    .we    (imem_we),
    .waddr (imem_addr),
    .wdata (imem_wdata),
    .raddr (fetch_addr),
    .insn  (insn)
  );

  rv_decoder rv_decoder_inst (
    .insn (insn),
    .ctrl (ctrl)
  );

  rv_regfile rv_regfile_inst (
    .clk      (clk),
    .rst      (rst),
    .we       (rf_we),
    .rd       (ctrl.rd),
    .rd_data  (alu_result),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_data;

  rv_alu rv_alu_inst (
    .op     (ctrl.alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (alu_result)
  );

  rv_pc_unit rv_pc_unit_inst (
    .clk      (clk),
    .rst      (rst),
    .run      (run),
    .ctrl     (ctrl),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc),
    .halt     (halt)
  );

  // an instruction retires only while running and not halted
  assign exec  = run && !halt;
  assign rf_we = exec && ctrl.reg_we;

  // trace shows x0 writes too, the register file drops them
  assign wb = '{valid: rf_we, rd: ctrl.rd, data: alu_result};

endmodule

//--- include/rv_tb_model.svh
// reference ISA model, encoders and random programs, included by the testbench after the import
`ifndef RV_TB_MODEL_SVH
`define RV_TB_MODEL_SVH

word_t m_regs [32];
word_t m_pc;
logic  m_halt;
insn_t gen_prog [IMEM_WORDS];

function automatic void model_reset();
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = '0;
  end
  m_pc   = '0;
  m_halt = 1'b0;
endfunction

function automatic word_t model_alu(input funct3_t f3, input logic alt, input word_t a,
                                    input word_t b);
  case (f3)
    F3_ADD_SUB: return alt ? a - b : a + b;
    F3_SLL:     return a << b[4:0];
    F3_SLT:     return {31'd0, $signed(a) < $signed(b)};
    F3_SLTU:    return {31'd0, a < b};
    F3_XOR:     return a ^ b;
    F3_SRL_SRA: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    F3_OR:      return a | b;
    default:    return a & b;
  endcase
endfunction

// sub and the arithmetic right shifts take the alternate funct7
function automatic logic funct7_legal(input funct3_t f3, input funct7_t f7,
                                      input logic imm_form);
  case (f3)
    F3_SLL:     return f7 == FUNCT7_BASE;
    F3_SRL_SRA: return f7 == FUNCT7_BASE || f7 == FUNCT7_ALT;
    F3_ADD_SUB: return imm_form || f7 == FUNCT7_BASE || f7 == FUNCT7_ALT;
    default:    return imm_form || f7 == FUNCT7_BASE;
  endcase
endfunction

function automatic logic model_taken(input funct3_t f3, input word_t a, input word_t b);
  case (f3)
    F3_BEQ:  return a == b;
    F3_BNE:  return a != b;
    F3_BLT:  return $signed(a) < $signed(b);
    F3_BGE:  return $signed(a) >= $signed(b);
    F3_BLTU: return a < b;
    F3_BGEU: return a >= b;
    default: return 1'b0;
  endcase
endfunction

// executes one instruction and returns the expected trace entry
function automatic wb_t model_step(input insn_t insn);
  funct3_t   f3;
  funct7_t   f7;
  reg_addr_t rd;
  word_t     a;
  word_t     b;
  word_t     imm_i;
  word_t     res;
  word_t     next_pc;
  logic      we;
  f3      = insn[14:12];
  f7      = insn[31:25];
  rd      = insn[11:7];
  a       = m_regs[insn[19:15]];
  b       = m_regs[insn[24:20]];
  imm_i   = {{20{insn[31]}}, insn[31:20]};
  res     = '0;
  we      = 1'b0;
  next_pc = m_pc + PC_STEP;
  m_halt  = 1'b0;
  case (insn[6:0])
    OP_LUI: begin
      we  = 1'b1;
      res = {insn[31:12], 12'd0};
    end
    OP_REG_IMM: begin
      we  = funct7_legal(f3, f7, 1'b1);
      res = model_alu(f3, f7 == FUNCT7_ALT && f3 == F3_SRL_SRA, a, imm_i);
    end
    OP_REG_REG: begin
      we  = funct7_legal(f3, f7, 1'b0);
      res = model_alu(f3, f7 == FUNCT7_ALT, a, b);
    end
    OP_BRANCH: begin
      if (model_taken(f3, a, b)) begin
        next_pc = m_pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      end
    end
    OP_ENVIRON: m_halt = (insn[31:7] == '0);
    default: ;
  endcase
  if (we && rd != '0) begin
    m_regs[rd] = res;
  end
  m_pc = m_halt ? m_pc : next_pc;
  return '{valid: we, rd: rd, data: res};
endfunction

function automatic insn_t enc_r(funct3_t f3, funct7_t f7, reg_addr_t rd, reg_addr_t rs1,
                                reg_addr_t rs2);
  return {f7, rs2, rs1, f3, rd, OP_REG_REG};
endfunction

function automatic insn_t enc_i(funct3_t f3, reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
  return {imm, rs1, f3, rd, OP_REG_IMM};
endfunction

function automatic insn_t enc_lui(reg_addr_t rd, logic [19:0] imm);
  return {imm, rd, OP_LUI};
endfunction

// byte offset whose bit 0 is dropped
function automatic insn_t enc_b(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2, logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
endfunction

function automatic insn_t enc_ecall();
  return {25'd0, OP_ENVIRON};
endfunction

function automatic int rand_below(inout integer seed, input int n);
  return int'($unsigned($random(seed)) % n);
endfunction

// fills gen_prog with len words ending in an ecall
function automatic void gen_program(inout integer seed, input int len);
  int      kind;
  int      span;
  funct3_t f3;
  for (int i = 0; i < len - 1; i++) begin
    kind = rand_below(seed, 16);
    f3   = funct3_t'(rand_below(seed, 8));
    if (kind == 0) begin
      // custom-0 opcode is never decoded
      gen_prog[i] = {25'($random(seed)), 7'b000_1011};
    end else if (kind < 3) begin
      gen_prog[i] = enc_lui(5'($random(seed)), 20'($random(seed)));
    end else if (kind < 6) begin
      // forward only and never past the final ecall
      span = 1 + rand_below(seed, (len - 1 - i < 4) ? len - 1 - i : 4);
      f3 = funct3_t'(rand_below(seed, 6));
      f3 = (f3 < 3'd2) ? f3 : f3 + 3'd2;
      gen_prog[i] = enc_b(f3, 5'($random(seed)), 5'($random(seed)), 13'(span * 4));
    end else if (kind < 11) begin
      gen_prog[i] = enc_i(f3, 5'($random(seed)), 5'($random(seed)), 12'($random(seed)));
      if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
        gen_prog[i][31:25] = (f3 == F3_SRL_SRA && kind[0]) ? FUNCT7_ALT : FUNCT7_BASE;
      end
    end else begin
      gen_prog[i] = enc_r(f3, ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && kind[0]) ?
                          FUNCT7_ALT : FUNCT7_BASE,
                          5'($random(seed)), 5'($random(seed)), 5'($random(seed)));
    end
  end
  gen_prog[len-1] = enc_ecall();
endfunction

`endif

//--- verification/rv_core_tb.sv
// testbench for the single-cycle core that runs directed and random programs against an ISA model
`timescale 1ns/10ps

module rv_core_tb;
  import rv_core_pkg::*;

  `include "rv_tb_model.svh"

  localparam int TIMEOUT_CYCLES = 1000;
  localparam int RANDOM_PROGRAMS = 20;

  logic       clk;
  logic       rst;
  logic       run;
  logic       imem_we;
  imem_addr_t imem_addr;
  insn_t      imem_wdata;
  word_t      pc;
  logic       halt;
  wb_t        wb;

  integer seed;
  int     prog_len;
  logic   checking;
  word_t  exp_pc;
  wb_t    exp_wb;

  rv_core_top rv_core_top_inst (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .pc         (pc),
    .halt       (halt),
    .wb         (wb)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic check(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "stopping at first error");
    end
  endtask

  // outputs are settled at the falling edge
  // the model steps once for every checked cycle
  always @(negedge clk) begin
    if (checking) begin
      exp_pc = m_pc;
      exp_wb = model_step(gen_prog[imem_addr_t'(exp_pc >> 2)]);
      check("pc", pc, exp_pc);
      check("halt", word_t'(halt), word_t'(m_halt));
      check("wb.valid", word_t'(wb.valid), word_t'(exp_wb.valid));
      if (exp_wb.valid) begin
        check("wb.rd", word_t'(wb.rd), word_t'(exp_wb.rd));
        check("wb.data", wb.data, exp_wb.data);
      end
    end
  end

  task automatic append_insn(input insn_t w);
    gen_prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_addr  <= imem_addr_t'(i);
      imem_wdata <= gen_prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
  endtask

  // stopped core must sit at pc 0 without tracing anything
  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check("idle pc", pc, '0);
      check("idle halt", word_t'(halt), '0);
      check("idle wb.valid", word_t'(wb.valid), '0);
    end
  endtask

  task automatic run_program();
    int cycles;
    load_program();
    @(posedge clk);
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    model_reset();
    @(posedge clk);
    run      <= 1'b1;
    checking = 1'b1;
    cycles   = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("timeout: core never halted within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "run timed out");
      end
    end while (!halt);
    // pc and trace must stay frozen after ecall
    repeat (4) @(negedge clk);
    @(posedge clk);
    run      <= 1'b0;
    checking = 1'b0;
  endtask

  task automatic build_reg_imm();
    prog_len = 0;
    append_insn(enc_i(F3_ADD_SUB, 5'd1, 5'd0, 12'hffb));
    append_insn(enc_i(F3_ADD_SUB, 5'd2, 5'd1, 12'hf9c));
    append_insn(enc_i(F3_SLT, 5'd3, 5'd1, 12'hffc));
    append_insn(enc_i(F3_SLTU, 5'd4, 5'd1, 12'h003));
    append_insn(enc_i(F3_SLTU, 5'd11, 5'd2, 12'hfff));
    append_insn(enc_i(F3_XOR, 5'd5, 5'd1, 12'h0f0));
    append_insn(enc_i(F3_OR, 5'd6, 5'd2, 12'h123));
    append_insn(enc_i(F3_AND, 5'd7, 5'd1, 12'h7f0));
    append_insn(enc_i(F3_SLL, 5'd8, 5'd1, {FUNCT7_BASE, 5'd4}));
    append_insn(enc_i(F3_SRL_SRA, 5'd9, 5'd1, {FUNCT7_BASE, 5'd8}));
    append_insn(enc_i(F3_SRL_SRA, 5'd10, 5'd1, {FUNCT7_ALT, 5'd3}));
    append_insn(enc_ecall());
  endtask

  task automatic build_reg_reg();
    prog_len = 0;
    append_insn(enc_i(F3_ADD_SUB, 5'd1, 5'd0, 12'hff9));
    // 37 checks that shifts only use the low five bits
    append_insn(enc_i(F3_ADD_SUB, 5'd2, 5'd0, 12'd37));
    append_insn(enc_lui(5'd3, 20'h80001));
    append_insn(enc_r(F3_ADD_SUB, FUNCT7_BASE, 5'd4, 5'd1, 5'd2));
    append_insn(enc_r(F3_ADD_SUB, FUNCT7_ALT, 5'd5, 5'd1, 5'd2));
    append_insn(enc_r(F3_SLL, FUNCT7_BASE, 5'd6, 5'd1, 5'd2));
    append_insn(enc_r(F3_SRL_SRA, FUNCT7_BASE, 5'd7, 5'd1, 5'd2));
    append_insn(enc_r(F3_SRL_SRA, FUNCT7_ALT, 5'd8, 5'd1, 5'd2));
    append_insn(enc_r(F3_SLT, FUNCT7_BASE, 5'd9, 5'd1, 5'd2));
    append_insn(enc_r(F3_SLTU, FUNCT7_BASE, 5'd10, 5'd1, 5'd2));
    append_insn(enc_r(F3_SLT, FUNCT7_BASE, 5'd15, 5'd3, 5'd1));
    append_insn(enc_r(F3_XOR, FUNCT7_BASE, 5'd11, 5'd1, 5'd3));
    append_insn(enc_r(F3_OR, FUNCT7_BASE, 5'd12, 5'd2, 5'd3));
    append_insn(enc_r(F3_AND, FUNCT7_BASE, 5'd13, 5'd1, 5'd3));
    // traced write to x0 followed by reads of x0
    append_insn(enc_r(F3_ADD_SUB, FUNCT7_BASE, 5'd0, 5'd1, 5'd2));
    append_insn(enc_r(F3_ADD_SUB, FUNCT7_BASE, 5'd14, 5'd0, 5'd0));
    append_insn(enc_r(F3_OR, FUNCT7_BASE, 5'd16, 5'd0, 5'd2));
    append_insn(enc_ecall());
  endtask

  task automatic build_branches();
    prog_len = 0;
    append_insn(enc_i(F3_ADD_SUB, 5'd1, 5'd0, 12'd3));
    append_insn(enc_i(F3_ADD_SUB, 5'd2, 5'd0, 12'hfff));
    append_insn(enc_b(F3_BEQ, 5'd1, 5'd2, 13'd8));
    append_insn(enc_b(F3_BNE, 5'd1, 5'd2, 13'd8));
    append_insn(enc_i(F3_ADD_SUB, 5'd5, 5'd0, 12'd99));
    append_insn(enc_b(F3_BLT, 5'd2, 5'd1, 13'd8));
    append_insn(enc_i(F3_ADD_SUB, 5'd5, 5'd0, 12'd98));
    append_insn(enc_b(F3_BGE, 5'd2, 5'd1, 13'd8));
    append_insn(enc_b(F3_BLTU, 5'd2, 5'd1, 13'd8));
    append_insn(enc_b(F3_BGEU, 5'd2, 5'd1, 13'd8));
    append_insn(enc_i(F3_ADD_SUB, 5'd5, 5'd0, 12'd97));
    append_insn(enc_b(F3_BGE, 5'd1, 5'd2, 13'd8));
    append_insn(enc_i(F3_ADD_SUB, 5'd5, 5'd0, 12'd96));
    // countdown loop with a backward bne taken until x1 reaches zero
    append_insn(enc_i(F3_ADD_SUB, 5'd1, 5'd1, 12'hfff));
    append_insn(enc_b(F3_BNE, 5'd1, 5'd0, 13'h1ffc));
    append_insn(enc_b(F3_BEQ, 5'd1, 5'd0, 13'd8));
    append_insn(enc_i(F3_ADD_SUB, 5'd5, 5'd0, 12'd95));
    append_insn(enc_b(F3_BLTU, 5'd1, 5'd2, 13'd8));
    append_insn(enc_i(F3_ADD_SUB, 5'd5, 5'd0, 12'd94));
    append_insn(enc_b(F3_BLT, 5'd1, 5'd2, 13'd8));
    append_insn(enc_b(F3_BGEU, 5'd1, 5'd2, 13'd8));
    append_insn(enc_ecall());
  endtask

  task automatic build_illegal();
    prog_len = 0;
    append_insn(enc_i(F3_ADD_SUB, 5'd1, 5'd0, 12'd5));
    append_insn({25'h0_1234, 7'b111_1111});
    append_insn(enc_r(F3_ADD_SUB, 7'b000_0001, 5'd2, 5'd1, 5'd1));
    // equal operands would make a decoded beq jump here
    append_insn(enc_b(3'b010, 5'd1, 5'd1, 13'd8));
    append_insn({12'h001, 13'd0, OP_ENVIRON});
    append_insn(enc_i(F3_SLL, 5'd3, 5'd1, {FUNCT7_ALT, 5'd1}));
    append_insn(enc_i(F3_ADD_SUB, 5'd4, 5'd1, 12'd1));
    append_insn(enc_ecall());
  endtask

  initial begin
    int len;
    seed        = 32'h18f7_3bab;
    checking    = 1'b0;
    prog_len    = 0;
    rst         = 1'b1;
    run         = 1'b0;
    imem_we     = 1'b0;
    imem_addr   = '0;
    imem_wdata  = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    check_idle(6);

    build_reg_imm();
    run_program();
    build_reg_reg();
    run_program();
    build_branches();
    run_program();
    build_illegal();
    run_program();

    for (int n = 0; n < RANDOM_PROGRAMS; n++) begin
      len = 16 + rand_below(seed, 48);
      gen_program(seed, len);
      prog_len = len;
      run_program();
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- list.f
+incdir+include
hw/rv_core_pkg.sv
hw/rv_imem.sv
hw/rv_decoder.sv
hw/rv_alu.sv
hw/rv_regfile.sv
hw/rv_pc_unit.sv
hw/rv_core_top.sv
verification/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := rv_core_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
